/* hdl/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address width seen by the core
`define DC_ADDR_W 32

// core data word
`define DC_XLEN 64

// 64 sets per way
`define DC_SET_W 6

// byte offset inside a line
`define DC_OFF_W 5

// what is left of the address above index and offset
`define DC_TAG_W 21

// one cache line
`define DC_LINE_W 256

// 64-bit beats per line refill
`define DC_BEATS 4

// bytes per line, one byte enable each
`define DC_BYTES 32

`endif

/* hdl/dcacheCorePkg.sv */
`default_nettype none

`include "dcache_defines.svh"

package dcacheCorePkg;

  // request kinds issued by the core
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } cacheOp_e;

  // one core request, mask is per byte of wdata
  typedef struct packed {
    cacheOp_e              op;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_XLEN-1:0]   wdata;
    logic [7:0]            mask;
  } coreReq_t;

  // load return data
  typedef struct packed {
    logic [`DC_XLEN-1:0] rdata;
  } coreResp_t;

  // registered contents of one way for the looked-up set
  typedef struct packed {
    logic                  hit;
    logic                  valid;
    logic                  dirty;
    logic [`DC_TAG_W-1:0]  tag;
    logic [`DC_LINE_W-1:0] data;
  } wayLookup_t;

  // write command into one way
  typedef struct packed {
    logic [`DC_SET_W-1:0]  idx;
    logic [`DC_LINE_W-1:0] data;
    logic [`DC_BYTES-1:0]  byteEn;
    logic                  tagWr;
    logic [`DC_TAG_W-1:0]  tag;
    logic                  setDirty;
    logic                  clrDirty;
  } wayWrite_t;

endpackage

`default_nettype wire

/* hdl/dcacheMemPkg.sv */
`default_nettype none

`include "dcache_defines.svh"

package dcacheMemPkg;

  // line refill request, offset bits are zero
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
  } memRdReq_t;

  // one refill beat from memory
  typedef struct packed {
    logic [`DC_XLEN-1:0] data;
    logic                last;
  } memBeat_t;

  // dirty victim line going back to memory
  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_LINE_W-1:0] line;
  } memWb_t;

  // miss handling states of the controller
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    COMPARE    = 3'd1,
    WRITEBACK  = 3'd2,
    REFILLREQ  = 3'd3,
    REFILLDATA = 3'd4,
    INSTALL    = 3'd5
  } ctrlState_e;

endpackage

`default_nettype wire

/* hdl/dcacheWay.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheWay (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          lookupEn_i,
  input  wire [`DC_SET_W-1:0]          lookupIdx_i,
  input  wire [`DC_TAG_W-1:0]          lookupTag_i,
  input  wire                          wrEn_i,
  input  wire dcacheCorePkg::wayWrite_t wr_i,
  output dcacheCorePkg::wayLookup_t    lookup_o
);

  localparam int SETS = 1 << `DC_SET_W;

  logic [`DC_TAG_W-1:0]  tagArr  [SETS];
  logic [`DC_LINE_W-1:0] dataArr [SETS];
  logic [SETS-1:0]       validArr;
  logic [SETS-1:0]       dirtyArr;

  logic [`DC_TAG_W-1:0]  tagQ;
  logic [`DC_LINE_W-1:0] dataQ;
  logic                  validQ;
  logic                  dirtyQ;

  logic                  fwd;
  logic [`DC_LINE_W-1:0] mergedLine;
  logic                  validNext;
  logic                  dirtyNext;

  // write and lookup on the same set in one cycle
  assign fwd = wrEn_i && (wr_i.idx == lookupIdx_i);

  // line as it looks after this cycle's write
  always_comb begin
    mergedLine = dataArr[wr_i.idx];
    for (int b = 0; b < `DC_BYTES; b++) begin
      if (wr_i.byteEn[b]) begin
        mergedLine[b*8 +: 8] = wr_i.data[b*8 +: 8];
      end
    end
  end

  always_comb begin
    validNext = validArr[lookupIdx_i];
    dirtyNext = dirtyArr[lookupIdx_i];
    if (fwd) begin
      validNext = validNext | wr_i.tagWr;
      if (wr_i.setDirty) begin
        dirtyNext = 1'b1;
      end else if (wr_i.clrDirty) begin
        dirtyNext = 1'b0;
      end
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      dataArr[wr_i.idx] <= mergedLine;
      if (wr_i.tagWr) begin
        tagArr[wr_i.idx] <= wr_i.tag;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (wrEn_i) begin
      if (wr_i.tagWr) begin
        validArr[wr_i.idx] <= 1'b1;
      end
      if (wr_i.setDirty) begin
        dirtyArr[wr_i.idx] <= 1'b1;
      end else if (wr_i.clrDirty) begin
        dirtyArr[wr_i.idx] <= 1'b0;
      end
    end
  end

  // synchronous read, write-first on a set collision
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ  <= (fwd && wr_i.tagWr) ? wr_i.tag : tagArr[lookupIdx_i];
      dataQ <= fwd ? mergedLine : dataArr[lookupIdx_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
      dirtyQ <= 1'b0;
    end else if (lookupEn_i) begin
      validQ <= validNext;
      dirtyQ <= dirtyNext;
    end
  end

  always_comb begin
    lookup_o.hit   = validQ && (tagQ == lookupTag_i);
    lookup_o.valid = validQ;
    lookup_o.dirty = dirtyQ;
    lookup_o.tag   = tagQ;
    lookup_o.data  = dataQ;
  end

endmodule

`default_nettype wire

/* hdl/dcacheCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheCtrl (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            reqValid_i,
  input  wire dcacheCorePkg::coreReq_t   req_i,
  output logic                           reqReady_o,
  output logic                           respValid_o,
  output dcacheCorePkg::coreResp_t       resp_o,
  output logic                           lookupEn_o,
  output logic [`DC_SET_W-1:0]           lookupIdx_o,
  output logic [`DC_TAG_W-1:0]           lookupTag_o,
  input  wire dcacheCorePkg::wayLookup_t way0_i,
  input  wire dcacheCorePkg::wayLookup_t way1_i,
  output logic                           wrEn0_o,
  output logic                           wrEn1_o,
  output dcacheCorePkg::wayWrite_t       wr0_o,
  output dcacheCorePkg::wayWrite_t       wr1_o,
  output logic                           memRdValid_o,
  input  wire                            memRdReady_i,
  output dcacheMemPkg::memRdReq_t        memRdReq_o,
  input  wire                            memBeatValid_i,
  input  wire dcacheMemPkg::memBeat_t    memBeat_i,
  output logic                           wbValid_o,
  input  wire                            wbReady_i,
  output dcacheMemPkg::memWb_t           wb_o
);

  localparam int BEAT_W = $clog2(`DC_BEATS);
  localparam int SETS   = 1 << `DC_SET_W;

  dcacheMemPkg::ctrlState_e state;
  dcacheMemPkg::ctrlState_e stateNext;

  dcacheCorePkg::coreReq_t   reqQ;
  dcacheCorePkg::wayLookup_t pickLk;
  dcacheCorePkg::wayLookup_t victimLk;
  dcacheCorePkg::wayWrite_t  wrCmd;

  logic [`DC_SET_W-1:0]  reqIdx;
  logic [`DC_TAG_W-1:0]  reqTag;
  logic [1:0]            wordSel;
  logic                  accept;
  logic                  hit;
  logic                  isStore;
  logic                  storeHit;
  logic                  installing;
  logic                  victimPick;
  logic                  victimWay;
  logic [SETS-1:0]       rrBits;
  logic [BEAT_W-1:0]     beatCnt;
  logic [`DC_LINE_W-1:0] refillBuf;
  logic [`DC_LINE_W-1:0] hitLine;
  logic [7:0]            shMask;
  logic [`DC_XLEN-1:0]   shData;
  logic [`DC_BYTES-1:0]  storeBe;

  assign reqIdx  = reqQ.addr[`DC_OFF_W +: `DC_SET_W];
  assign reqTag  = reqQ.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign wordSel = reqQ.addr[`DC_OFF_W-1:3];
  assign isStore = (reqQ.op == dcacheCorePkg::OP_STORE);

  assign hit        = way0_i.hit || way1_i.hit;
  assign storeHit   = (state == dcacheMemPkg::COMPARE) && hit && isStore;
  assign installing = (state == dcacheMemPkg::INSTALL);

  // a load hit lets the next request in back to back
  assign reqReady_o = (state == dcacheMemPkg::IDLE) ||
                      ((state == dcacheMemPkg::COMPARE) && hit && !isStore);
  assign accept     = reqValid_i && reqReady_o;

  // new request indexes straight from the core, install re-reads its own set
  assign lookupEn_o  = accept || installing;
  assign lookupIdx_o = accept ? req_i.addr[`DC_OFF_W +: `DC_SET_W] : reqIdx;
  assign lookupTag_o = reqTag;

  // way 0 wins if both ever claim the tag
  assign hitLine      = way0_i.hit ? way0_i.data : way1_i.data;
  assign respValid_o  = (state == dcacheMemPkg::COMPARE) && hit;
  assign resp_o.rdata = hitLine[wordSel*`DC_XLEN +: `DC_XLEN];

  // invalid way first, then the set's round-robin bit
  assign victimPick = !way0_i.valid ? 1'b0 :
                      !way1_i.valid ? 1'b1 : rrBits[reqIdx];
  assign pickLk     = victimPick ? way1_i : way0_i;
  assign victimLk   = victimWay ? way1_i : way0_i;

  always_comb begin
    stateNext = state;
    case (state)
      dcacheMemPkg::IDLE: begin
        if (accept) begin
          stateNext = dcacheMemPkg::COMPARE;
        end
      end
      dcacheMemPkg::COMPARE: begin
        if (hit) begin
          stateNext = accept ? dcacheMemPkg::COMPARE : dcacheMemPkg::IDLE;
        end else if (pickLk.valid && pickLk.dirty) begin
          stateNext = dcacheMemPkg::WRITEBACK;
        end else begin
          stateNext = dcacheMemPkg::REFILLREQ;
        end
      end
      dcacheMemPkg::WRITEBACK: begin
        if (wbReady_i) begin
          stateNext = dcacheMemPkg::REFILLREQ;
        end
      end
      dcacheMemPkg::REFILLREQ: begin
        if (memRdReady_i) begin
          stateNext = dcacheMemPkg::REFILLDATA;
        end
      end
      dcacheMemPkg::REFILLDATA: begin
        if (memBeatValid_i && memBeat_i.last) begin
          stateNext = dcacheMemPkg::INSTALL;
        end
      end
      dcacheMemPkg::INSTALL: begin
        stateNext = dcacheMemPkg::COMPARE;
      end
      default: begin
        stateNext = dcacheMemPkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcacheMemPkg::IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
  end

  // victim and round-robin bookkeeping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimWay <= 1'b0;
      rrBits    <= '0;
    end else begin
      if ((state == dcacheMemPkg::COMPARE) && !hit) begin
        victimWay <= victimPick;
      end
      if (installing) begin
        rrBits[reqIdx] <= ~rrBits[reqIdx];
      end
    end
  end

  // beat k lands in bytes 8k..8k+7
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (state == dcacheMemPkg::REFILLREQ) begin
      beatCnt <= '0;
    end else if ((state == dcacheMemPkg::REFILLDATA) && memBeatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == dcacheMemPkg::REFILLDATA) && memBeatValid_i) begin
      refillBuf[beatCnt*`DC_XLEN +: `DC_XLEN] <= memBeat_i.data;
    end
  end

  // store data and mask aligned to the byte address
  assign shMask  = reqQ.mask << reqQ.addr[2:0];
  assign shData  = reqQ.wdata << {reqQ.addr[2:0], 3'b000};
  assign storeBe = {{(`DC_BYTES-8){1'b0}}, shMask} << {wordSel, 3'b000};

  always_comb begin
    wrCmd.idx      = reqIdx;
    wrCmd.data     = installing ? refillBuf : {`DC_BEATS{shData}};
    wrCmd.byteEn   = installing ? {`DC_BYTES{1'b1}} : storeBe;
    wrCmd.tagWr    = installing;
    wrCmd.tag      = reqTag;
    wrCmd.setDirty = !installing;
    wrCmd.clrDirty = installing;
  end

  assign wrEn0_o = (installing && !victimWay) || (storeHit && way0_i.hit);
  assign wrEn1_o = (installing && victimWay) || (storeHit && !way0_i.hit);
  assign wr0_o   = wrCmd;
  assign wr1_o   = wrCmd;

  // victim line stays in the lookup registers until install
  assign wbValid_o    = (state == dcacheMemPkg::WRITEBACK);
  assign wb_o.addr    = {victimLk.tag, reqIdx, {`DC_OFF_W{1'b0}}};
  assign wb_o.line    = victimLk.data;
  assign memRdValid_o = (state == dcacheMemPkg::REFILLREQ);
  assign memRdReq_o.addr = {reqTag, reqIdx, {`DC_OFF_W{1'b0}}};

endmodule

`default_nettype wire

/* hdl/dcacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTop (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          reqValid_i,
  input  wire dcacheCorePkg::coreReq_t req_i,
  output logic                         reqReady_o,
  output logic                         respValid_o,
  output dcacheCorePkg::coreResp_t     resp_o,
  output logic                         memRdValid_o,
  input  wire                          memRdReady_i,
  output dcacheMemPkg::memRdReq_t      memRdReq_o,
  input  wire                          memBeatValid_i,
  input  wire dcacheMemPkg::memBeat_t  memBeat_i,
  output logic                         wbValid_o,
  input  wire                          wbReady_i,
  output dcacheMemPkg::memWb_t         wb_o
);

  logic                      lookupEn;
  logic [`DC_SET_W-1:0]      lookupIdx;
  logic [`DC_TAG_W-1:0]      lookupTag;
  dcacheCorePkg::wayLookup_t way0Lk;
  dcacheCorePkg::wayLookup_t way1Lk;
  logic                      wrEn0;
  logic                      wrEn1;
  dcacheCorePkg::wayWrite_t  wr0;
  dcacheCorePkg::wayWrite_t  wr1;

  // both ways see the same lookup, writes are per way
  dcacheWay u_way0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookupEn_i  (lookupEn),
    .lookupIdx_i (lookupIdx),
    .lookupTag_i (lookupTag),
    .wrEn_i      (wrEn0),
    .wr_i        (wr0),
    .lookup_o    (way0Lk)
  );

  dcacheWay u_way1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookupEn_i  (lookupEn),
    .lookupIdx_i (lookupIdx),
    .lookupTag_i (lookupTag),
    .wrEn_i      (wrEn1),
    .wr_i        (wr1),
    .lookup_o    (way1Lk)
  );

  dcacheCtrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid_i),
    .req_i          (req_i),
    .reqReady_o     (reqReady_o),
    .respValid_o    (respValid_o),
    .resp_o         (resp_o),
    .lookupEn_o     (lookupEn),
    .lookupIdx_o    (lookupIdx),
    .lookupTag_o    (lookupTag),
    .way0_i         (way0Lk),
    .way1_i         (way1Lk),
    .wrEn0_o        (wrEn0),
    .wrEn1_o        (wrEn1),
    .wr0_o          (wr0),
    .wr1_o          (wr1),
    .memRdValid_o   (memRdValid_o),
    .memRdReady_i   (memRdReady_i),
    .memRdReq_o     (memRdReq_o),
    .memBeatValid_i (memBeatValid_i),
    .memBeat_i      (memBeat_i),
    .wbValid_o      (wbValid_o),
    .wbReady_i      (wbReady_i),
    .wb_o           (wb_o)
  );

endmodule

`default_nettype wire

/* sim/dcache_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module dcacheAssert (
  input wire clk,
  input wire rst_n,
  input wire reqValid_i,
  input wire reqReady_i,
  input wire respValid_i,
  input wire rdValid_i,
  input wire rdReady_i,
  input wire wbValid_i,
  input wire wbReady_i
);

  int failCount;

  initial begin
    failCount = 0;
  end

  // refill request is held until memory takes it
  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdValid_i && !rdReady_i |=> rdValid_i)
  else begin
    failCount++;
    $error("memRdValid_o dropped before memRdReady_i");
  end

  wbHold: assert property (@(posedge clk) disable iff (!rst_n)
    wbValid_i && !wbReady_i |=> wbValid_i)
  else begin
    failCount++;
    $error("wbValid_o dropped before wbReady_i");
  end

  // one response per accepted request
  respOnce: assert property (@(posedge clk) disable iff (!rst_n)
    respValid_i && !(reqValid_i && reqReady_i) |=> !respValid_i)
  else begin
    failCount++;
    $error("respValid_o high twice without a new acceptance");
  end

  memExcl: assert property (@(posedge clk) disable iff (!rst_n)
    !(wbValid_i && rdValid_i))
  else begin
    failCount++;
    $error("write-back and refill request raised together");
  end

endmodule

`default_nettype wire

/* sim/dcacheTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcacheTb;

  localparam int RST_CYCLES = 5;

  logic                      clk;
  logic                      rst_n;
  logic                      reqValid_i;
  dcacheCorePkg::coreReq_t   req_i;
  logic                      reqReady_o;
  logic                      respValid_o;
  dcacheCorePkg::coreResp_t  resp_o;
  logic                      memRdValid_o;
  logic                      memRdReady_i;
  dcacheMemPkg::memRdReq_t   memRdReq_o;
  logic                      memBeatValid_i;
  dcacheMemPkg::memBeat_t    memBeat_i;
  logic                      wbValid_o;
  logic                      wbReady_i;
  dcacheMemPkg::memWb_t      wb_o;

  logic [15:0]               lfsr;
  int                        issued;
  int                        rdCount;
  int                        wbCount;
  dcacheMemPkg::memRdReq_t   lastRd;
  dcacheMemPkg::memWb_t      lastWb;
  logic [`DC_ADDR_W-1:0]     lineA;
  logic [`DC_ADDR_W-1:0]     lineW;

  // shadow and memory lines share one table keyed by {isMem, line address}
  logic [`DC_ADDR_W:0]       tblKey [$];
  logic [`DC_LINE_W-1:0]     tblLine [$];

  dcacheTop u_dcacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid_i),
    .req_i          (req_i),
    .reqReady_o     (reqReady_o),
    .respValid_o    (respValid_o),
    .resp_o         (resp_o),
    .memRdValid_o   (memRdValid_o),
    .memRdReady_i   (memRdReady_i),
    .memRdReq_o     (memRdReq_o),
    .memBeatValid_i (memBeatValid_i),
    .memBeat_i      (memBeat_i),
    .wbValid_o      (wbValid_o),
    .wbReady_i      (wbReady_i),
    .wb_o           (wb_o)
  );

  bind dcacheCtrl dcacheAssert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid_i),
    .reqReady_i  (reqReady_o),
    .respValid_i (respValid_o),
    .rdValid_i   (memRdValid_o),
    .rdReady_i   (memRdReady_i),
    .wbValid_i   (wbValid_o),
    .wbReady_i   (wbReady_i)
  );

  always #10 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] randBits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsrBit()};
    end
    return v;
  endfunction

  // fill byte folds every address bit
  function automatic logic [`DC_LINE_W-1:0] patternLine(logic [31:0] la);
    logic [`DC_LINE_W-1:0] line;
    logic [31:0]           a;
    for (int b = 0; b < `DC_BYTES; b++) begin
      a = la + b;
      line[b*8 +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ {a[28:24], a[31:29]} ^ 8'h96;
    end
    return line;
  endfunction

  // shadow falls back to memory and memory to the fill pattern
  function automatic logic [`DC_LINE_W-1:0] lineGet(logic isMem, logic [31:0] la);
    for (int i = 0; i < tblKey.size(); i++) begin
      if (tblKey[i] == {isMem, la}) begin
        return tblLine[i];
      end
    end
    return isMem ? patternLine(la) : lineGet(1'b1, la);
  endfunction

  function automatic void linePut(logic isMem, logic [31:0] la, logic [`DC_LINE_W-1:0] line);
    for (int i = 0; i < tblKey.size(); i++) begin
      if (tblKey[i] == {isMem, la}) begin
        tblLine[i] = line;
        return;
      end
    end
    tblKey.push_back({isMem, la});
    tblLine.push_back(line);
  endfunction

  function automatic logic [63:0] shadowWord(logic [31:0] a);
    logic [`DC_LINE_W-1:0] line;
    line = lineGet(1'b0, {a[31:5], 5'b0});
    return line[a[4:3]*64 +: 64];
  endfunction

  // mask and data shift up by the low address bits and bytes past the word drop
  function automatic void storeShadow(logic [31:0] a, logic [63:0] d, logic [7:0] m);
    logic [`DC_LINE_W-1:0] line;
    int                    pos;
    line = lineGet(1'b0, {a[31:5], 5'b0});
    for (int b = 0; b < 8; b++) begin
      pos = a[2:0] + b;
      if (m[b] && pos < 8) begin
        line[(a[4:3]*8 + pos)*8 +: 8] = d[b*8 +: 8];
      end
    end
    linePut(1'b0, {a[31:5], 5'b0}, line);
  endfunction

  function automatic logic [31:0] mkAddr(logic [20:0] tag, logic [5:0] idx, logic [4:0] off);
    return {tag, idx, off};
  endfunction

  task automatic abortRun();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkValue(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      $display("FAIL @%0t: %s is %0d, expected %0d", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkResp(dcacheCorePkg::coreResp_t got, dcacheCorePkg::coreResp_t exp,
                           string what);
    if (got !== exp) begin
      $display("FAIL @%0t: %s data %h, expected %h", $time, what, got.rdata, exp.rdata);
      abortRun();
    end
  endtask

  task automatic checkWb(dcacheMemPkg::memWb_t got, dcacheMemPkg::memWb_t exp, string what);
    if (got !== exp) begin
      $display("FAIL @%0t: %s addr %h line %h, expected addr %h line %h",
               $time, what, got.addr, got.line, exp.addr, exp.line);
      abortRun();
    end
  endtask

  task automatic checkRdReq(dcacheMemPkg::memRdReq_t got, dcacheMemPkg::memRdReq_t exp,
                            string what);
    if (got !== exp) begin
      $display("FAIL @%0t: %s addr %h, expected %h", $time, what, got.addr, exp.addr);
      abortRun();
    end
  endtask

  task automatic applyReset();
    rst_n      = 1'b0;
    reqValid_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic driveReq(dcacheCorePkg::cacheOp_e op, logic [31:0] a, logic [63:0] d,
                          logic [7:0] m);
    issued++;
    req_i.op    = op;
    req_i.addr  = a;
    req_i.wdata = d;
    req_i.mask  = m;
    reqValid_i  = 1'b1;
  endtask

  // lat counts cycles from the accepting edge to the response
  task automatic access(dcacheCorePkg::cacheOp_e op, logic [31:0] a, logic [63:0] d,
                        logic [7:0] m, output dcacheCorePkg::coreResp_t resp,
                        output int lat);
    logic wasReady;
    if (op == dcacheCorePkg::OP_STORE) begin
      storeShadow(a, d, m);
    end
    driveReq(op, a, d, m);
    do begin
      wasReady = reqReady_o;
      @(posedge clk);
      #1;
    end while (!wasReady);
    reqValid_i = 1'b0;
    lat = 1;
    while (respValid_o !== 1'b1) begin
      @(posedge clk);
      #1;
      lat++;
    end
    resp = resp_o;
  endtask

  task automatic expectLoad(logic [31:0] a, logic miss);
    dcacheCorePkg::coreResp_t resp;
    dcacheCorePkg::coreResp_t exp;
    dcacheMemPkg::memRdReq_t  expRd;
    int                       lat;
    int                       rd0;
    rd0 = rdCount;
    exp.rdata = shadowWord(a);
    access(dcacheCorePkg::OP_LOAD, a, '0, '0, resp, lat);
    checkResp(resp, exp, "load");
    if (miss) begin
      checkValue(rdCount, rd0 + 1, "refills for a missing load");
      expRd.addr = {a[31:5], 5'b0};
      checkRdReq(lastRd, expRd, "refill request");
    end else begin
      checkValue(lat, 1, "load hit latency");
      checkValue(rdCount, rd0, "refills for a hitting load");
    end
  endtask

  task automatic storeCheck(logic [31:0] a, logic [63:0] d, logic [7:0] m);
    dcacheCorePkg::coreResp_t resp;
    int                       lat;
    int                       rd0;
    rd0 = rdCount;
    access(dcacheCorePkg::OP_STORE, a, d, m, resp, lat);
    checkValue(lat, 1, "store hit latency");
    checkValue(rdCount, rd0, "refills for a store hit");
  endtask

  task automatic serveWb();
    int gap;
    gap = int'(randBits(2));
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    wbReady_i = 1'b1;
    lastWb = wb_o;
    wbCount++;
    linePut(1'b1, wb_o.addr, wb_o.line);
    @(posedge clk);
    #1;
    wbReady_i = 1'b0;
  endtask

  task automatic serveRefill();
    logic [`DC_LINE_W-1:0] line;
    int                    gap;
    gap = int'(randBits(2));
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    memRdReady_i = 1'b1;
    lastRd = memRdReq_o;
    rdCount++;
    line = lineGet(1'b1, memRdReq_o.addr);
    @(posedge clk);
    #1;
    memRdReady_i = 1'b0;
    for (int k = 0; k < `DC_BEATS; k++) begin
      // optional idle cycle before each beat
      if (randBits(1) != 0) begin
        @(posedge clk);
        #1;
      end
      memBeatValid_i = 1'b1;
      memBeat_i.data = line[k*64 +: 64];
      memBeat_i.last = (k == `DC_BEATS - 1);
      @(posedge clk);
      #1;
      memBeatValid_i = 1'b0;
    end
    memBeat_i = '0;
  endtask

  task automatic testColdLoad();
    logic [31:0] a;
    checkValue(respValid_o, 0, "respValid_o after reset");
    checkValue(memRdValid_o, 0, "memRdValid_o after reset");
    checkValue(wbValid_o, 0, "wbValid_o after reset");
    checkValue(reqReady_o, 1, "reqReady_o after reset");
    a = mkAddr(21'(randBits(21)), 6'd3, 5'd8);
    expectLoad(a, 1'b1);
    expectLoad(a ^ 32'h18, 1'b0);
    lineA = a;
  endtask

  task automatic testStoreHits();
    for (int i = 0; i < 4; i++) begin
      storeCheck({lineA[31:5], 5'(randBits(5))}, randBits(64), 8'(randBits(8)));
    end
    for (int w = 0; w < 4; w++) begin
      expectLoad({lineA[31:5], 2'(w), 3'b000}, 1'b0);
    end
  endtask

  // invalid way first and then the round-robin bit toggled by each install
  task automatic testReplacement();
    logic [20:0] t;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    int          wb0;
    t   = 21'(randBits(21));
    a0  = mkAddr(t, 6'd9, 5'h00);
    a1  = mkAddr(t + 21'd1, 6'd9, 5'h10);
    a2  = mkAddr(t + 21'd2, 6'd9, 5'h08);
    wb0 = wbCount;
    expectLoad(a0, 1'b1);
    expectLoad(a1, 1'b1);
    expectLoad(a2, 1'b1);
    expectLoad(a1, 1'b0);
    expectLoad(a0, 1'b1);
    expectLoad(a2, 1'b0);
    expectLoad(a1, 1'b1);
    checkValue(wbCount, wb0, "write-backs from clean evictions");
  endtask

  task automatic testWriteBack();
    logic [20:0]          t;
    logic [31:0]          a0;
    dcacheMemPkg::memWb_t expWb;
    int                   wb0;
    t   = 21'(randBits(21));
    a0  = mkAddr(t, 6'd17, 5'h00);
    wb0 = wbCount;
    expectLoad(a0, 1'b1);
    storeCheck(a0 | 32'h08, randBits(64), 8'(randBits(8)));
    expectLoad(mkAddr(t + 21'd1, 6'd17, 5'h00), 1'b1);
    checkValue(wbCount, wb0, "write-backs while a way was free");
    // dirty line in way 0 goes out here
    expectLoad(mkAddr(t + 21'd2, 6'd17, 5'h00), 1'b1);
    checkValue(wbCount, wb0 + 1, "write-backs after the dirty eviction");
    expWb.addr = a0;
    expWb.line = lineGet(1'b0, a0);
    checkWb(lastWb, expWb, "dirty victim");
    expectLoad(mkAddr(t + 21'd3, 6'd17, 5'h00), 1'b1);
    expectLoad(a0 | 32'h08, 1'b1);
    checkValue(wbCount, wb0 + 1, "write-backs after clean evictions");
    lineW = a0;
  endtask

  task automatic testHitStream();
    logic [31:0]              addrs [8];
    dcacheCorePkg::coreResp_t exp;
    expectLoad(lineA, 1'b0);
    expectLoad(lineW, 1'b0);
    for (int i = 0; i < 8; i++) begin
      addrs[i] = (randBits(1) != 0) ? lineA : lineW;
      addrs[i][4:3] = 2'(randBits(2));
    end
    for (int i = 0; i <= 8; i++) begin
      if (i > 0) begin
        checkValue(respValid_o, 1, "response one cycle after a streamed acceptance");
        exp.rdata = shadowWord(addrs[i-1]);
        checkResp(resp_o, exp, "streamed load");
      end
      if (i < 8) begin
        checkValue(reqReady_o, 1, "reqReady_o during a run of hits");
        driveReq(dcacheCorePkg::OP_LOAD, addrs[i], '0, '0);
      end else begin
        reqValid_i = 1'b0;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic testMidReset();
    storeCheck(lineW, randBits(64), 8'hFF);
    applyReset();
    // cache contents are lost so the core now sees memory
    for (int i = 0; i < tblKey.size(); i++) begin
      if (!tblKey[i][`DC_ADDR_W]) begin
        tblLine[i] = lineGet(1'b1, tblKey[i][`DC_ADDR_W-1:0]);
      end
    end
    expectLoad(lineW, 1'b1);
    expectLoad(lineA, 1'b1);
  endtask

  initial begin : memModel
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && wbValid_o) begin
        serveWb();
      end else if (rst_n && memRdValid_o) begin
        serveRefill();
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 2 * RST_CYCLES + 200 * (issued + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles with %0d requests issued", cycles, issued);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    lfsr           = 16'd3;
    issued         = 0;
    rdCount        = 0;
    wbCount        = 0;
    reqValid_i     = 1'b0;
    req_i          = '0;
    memRdReady_i   = 1'b0;
    memBeatValid_i = 1'b0;
    memBeat_i      = '0;
    wbReady_i      = 1'b0;
    applyReset();
    testColdLoad();
    testStoreHits();
    testReplacement();
    testWriteBack();
    testHitStream();
    testMidReset();
    if (u_dcacheTop.u_ctrl.u_assert.failCount == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d assertion failures", u_dcacheTop.u_ctrl.u_assert.failCount);
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failures during the run");
    end
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/dcacheCorePkg.sv
hdl/dcacheMemPkg.sv
hdl/dcacheWay.sv
hdl/dcacheCtrl.sv
hdl/dcacheTop.sv
sim/dcache_assert.sv
sim/dcacheTb.sv
